//--- src.f
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_hazard.sv
source/rv_execute.sv
source/rv_data_mem.sv
source/rv_core_top.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f src.f

# The pass message decides the result, the simulator output is shown as it runs.
./obj_dir/Vrv_core_tb | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

//--- testbench/rv_core_tb.sv
module rv_core_tb;
    import rv_pkg::*;

    localparam int    TIMEOUT = 100;
    localparam inst_t NOP     = 32'h0000_0013;

    logic               clk;
    logic               arst_n;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    inst_t              imem_wdata;
    xlen_t              pc;
    logic               commit_valid;
    reg_addr_t          commit_rd;
    xlen_t              commit_data;

    int        seed = 32'hcc9d;
    inst_t     prog [$];
    reg_addr_t exp_rd [$];
    xlen_t     exp_data [$];

    rv_core_top dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .pc          (pc),
        .commit_valid(commit_valid),
        .commit_rd   (commit_rd),
        .commit_data (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction formats from the RV64I base encoding.
    function automatic inst_t itype(input int opc, input int f3, input int rd, input int rs1,
                                    input int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic inst_t rtype(input int f7, input int f3, input int rd, input int rs1,
                                    input int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
    endfunction

    function automatic inst_t sd(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b011, i[4:0], 7'h23};
    endfunction

    function automatic inst_t btype(input int f3, input int rs1, input int rs2, input int off);
        logic [12:0] b;
        b = 13'(off);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], 7'h63};
    endfunction

    function automatic inst_t jal(input int rd, input int off);
        logic [20:0] j;
        j = 21'(off);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'h6f};
    endfunction

    function automatic inst_t lui(input int rd, input int imm);
        return {20'(imm), 5'(rd), 7'h37};
    endfunction

    function automatic inst_t addi(input int rd, input int rs1, input int imm);
        return itype(7'h13, 0, rd, rs1, imm);
    endfunction

    function automatic inst_t ld(input int rd, input int rs1, input int imm);
        return itype(7'h03, 3, rd, rs1, imm);
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic xlen_t upper_imm(input logic [19:0] u);
        return {{32{u[19]}}, u, 12'h000};
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic value_error(input string name, input xlen_t got, input xlen_t want);
        stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, want));
    endtask

    task automatic expect_write(input int rd, input xlen_t data);
        exp_rd.push_back(5'(rd));
        exp_data.push_back(data);
    endtask

    task automatic hold_reset();
        arst_n = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // Commits must arrive in program order, one per retired write.
    task automatic collect_commits();
        int n;
        int idle;
        n = 0;
        idle = 0;
        while (n < exp_rd.size()) begin
            @(negedge clk);
            if (commit_valid) begin
                assert (commit_rd == exp_rd[n])
                    else value_error("commit_rd", xlen_t'(commit_rd), xlen_t'(exp_rd[n]));
                assert (commit_data == exp_data[n])
                    else value_error("commit_data", commit_data, exp_data[n]);
                n++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < TIMEOUT)
                    else stop_on_error($sformatf("no commit within %0d cycles, %0d of %0d seen",
                                                 TIMEOUT, n, exp_rd.size()));
            end
        end
        exp_rd.delete();
        exp_data.delete();
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!commit_valid)
                else stop_on_error($sformatf("unexpected commit to x%0d at %0t",
                                             commit_rd, $time));
        end
    endtask

    // The core is held in reset while the program is written.
    task automatic run_program();
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem_we    = 1'b1;
            imem_addr  = IMEM_AW'(i);
            imem_wdata = (i < prog.size()) ? prog[i] : NOP;
            @(negedge clk);
        end
        imem_we = 1'b0;
        prog.delete();
        hold_reset();
        collect_commits();
    endtask

    task automatic alu_forwarding();
        logic [11:0] ia;
        logic [11:0] ib;
        logic [11:0] ic;
        xlen_t       a;
        xlen_t       b;
        xlen_t       r3;
        xlen_t       r4;
        xlen_t       r5;
        xlen_t       r6;
        xlen_t       r7;
        xlen_t       r8;
        xlen_t       r9;
        ia = 12'($random(seed));
        ib = 12'($random(seed));
        ic = 12'($random(seed));
        a  = sext12(ia);
        b  = sext12(ib);
        r3 = a + b;
        r4 = r3 - a;
        r5 = r4 & r3;
        r6 = r5 | b;
        r7 = r6 ^ r4;
        r8 = ($signed(r7) < $signed(r3)) ? 64'd1 : 64'd0;
        r9 = ($signed(r3) < $signed(r7)) ? 64'd1 : 64'd0;
        prog.push_back(addi(1, 0, int'(ia)));
        prog.push_back(addi(2, 0, int'(ib)));
        prog.push_back(rtype(7'h00, 0, 3, 1, 2));
        prog.push_back(rtype(7'h20, 0, 4, 3, 1));
        prog.push_back(rtype(7'h00, 7, 5, 4, 3));
        prog.push_back(rtype(7'h00, 6, 6, 5, 2));
        prog.push_back(rtype(7'h00, 4, 7, 6, 4));
        prog.push_back(rtype(7'h00, 2, 8, 7, 3));
        prog.push_back(rtype(7'h00, 2, 9, 3, 7));
        prog.push_back(addi(10, 8, int'(ic)));
        prog.push_back(jal(0, 0));
        expect_write(1, a);
        expect_write(2, b);
        expect_write(3, r3);
        expect_write(4, r4);
        expect_write(5, r5);
        expect_write(6, r6);
        expect_write(7, r7);
        expect_write(8, r8);
        expect_write(9, r9);
        expect_write(10, r8 + sext12(ic));
        run_program();
        check_quiet(20);
    endtask

    task automatic upper_and_zero();
        prog.push_back(lui(11, 20'h12345));
        prog.push_back(lui(12, 20'hfedcb));
        prog.push_back(lui(0, 20'h55555));
        prog.push_back(addi(0, 11, 5));
        prog.push_back(rtype(7'h00, 0, 13, 0, 12));
        prog.push_back(rtype(7'h00, 0, 14, 0, 0));
        prog.push_back(jal(0, 0));
        expect_write(11, upper_imm(20'h12345));
        expect_write(12, upper_imm(20'hfedcb));
        expect_write(13, upper_imm(20'hfedcb));
        expect_write(14, 64'd0);
        run_program();
        check_quiet(20);
    endtask

    task automatic store_load_bubble();
        xlen_t v;
        v = upper_imm(20'habcde) + sext12(12'h345);
        prog.push_back(lui(1, 20'habcde));
        prog.push_back(addi(1, 1, 12'h345));
        prog.push_back(addi(2, 0, 64));
        prog.push_back(sd(1, 2, 8));
        prog.push_back(ld(3, 2, 8));
        prog.push_back(rtype(7'h00, 0, 4, 3, 1));
        prog.push_back(ld(5, 2, 8));
        prog.push_back(rtype(7'h20, 0, 6, 0, 5));
        prog.push_back(jal(0, 0));
        expect_write(1, upper_imm(20'habcde));
        expect_write(1, v);
        expect_write(2, 64'd64);
        expect_write(3, v);
        expect_write(4, v + v);
        expect_write(5, v);
        expect_write(6, 64'd0 - v);
        run_program();
        check_quiet(20);
    endtask

    task automatic branch_skips();
        prog.push_back(addi(1, 0, 7));
        prog.push_back(addi(2, 0, 7));
        prog.push_back(btype(0, 1, 2, 12));
        prog.push_back(addi(3, 0, 1));
        prog.push_back(addi(4, 0, 2));
        prog.push_back(btype(1, 1, 2, 12));
        prog.push_back(addi(5, 0, 3));
        prog.push_back(btype(0, 1, 0, 8));
        prog.push_back(addi(6, 0, 4));
        prog.push_back(btype(1, 1, 0, 12));
        prog.push_back(addi(7, 0, 5));
        prog.push_back(addi(8, 0, 6));
        prog.push_back(addi(9, 0, 9));
        prog.push_back(jal(0, 0));
        expect_write(1, 64'd7);
        expect_write(2, 64'd7);
        expect_write(5, 64'd3);
        expect_write(6, 64'd4);
        expect_write(9, 64'd9);
        run_program();
        check_quiet(20);
    endtask

    task automatic jump_and_loop();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(jal(2, 12));
        prog.push_back(addi(3, 0, 1));
        prog.push_back(addi(4, 0, 2));
        prog.push_back(addi(1, 1, -1));
        prog.push_back(btype(1, 1, 0, -4));
        prog.push_back(addi(5, 0, 11));
        prog.push_back(jal(0, 0));
        expect_write(1, 64'd5);
        expect_write(2, 64'd8);
        for (int k = 4; k >= 0; k--) begin
            expect_write(1, xlen_t'(k));
        end
        expect_write(5, 64'd11);
        run_program();
        check_quiet(20);
    endtask

    task automatic restart_after_reset();
        prog.push_back(addi(1, 0, 100));
        prog.push_back(addi(2, 0, 0));
        prog.push_back(addi(2, 2, 1));
        prog.push_back(jal(0, -4));
        expect_write(1, 64'd100);
        expect_write(2, 64'd0);
        expect_write(2, 64'd1);
        run_program();
        // The loop is still committing when reset hits.
        @(negedge clk);
        arst_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (pc == '0) else value_error("pc", pc, '0);
            assert (!commit_valid) else stop_on_error("commit_valid high while reset is held");
        end
        arst_n = 1'b1;
        expect_write(1, 64'd100);
        expect_write(2, 64'd0);
        expect_write(2, 64'd1);
        collect_commits();
    endtask

    initial begin
        arst_n     = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        alu_forwarding();
        upper_and_zero();
        store_load_bubble();
        branch_skips();
        jump_and_loop();
        restart_after_reset();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- source/rv_core_top.sv
module rv_core_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       imem_we,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
    input  rv_pkg::inst_t              imem_wdata,
    output rv_pkg::xlen_t              pc,
    output logic                       commit_valid,
    output rv_pkg::reg_addr_t          commit_rd,
    output rv_pkg::xlen_t              commit_data
);
    import rv_pkg::*;

    inst_t  if_inst;
    inst_t  if_id_inst;
    xlen_t  if_id_pc;
    dec_t   id_dec;
    id_ex_t id_ex;
    ex_me_t ex_result;
    ex_me_t ex_me;
    me_wb_t me_result;
    me_wb_t me_wb;
    xlen_t  rf_rs1;
    xlen_t  rf_rs2;
    xlen_t  fwd_rs1;
    xlen_t  fwd_rs2;
    xlen_t  ex_target;
    xlen_t  dmem_rdata;
    xlen_t  me_data;
    logic   taken;
    logic   bubble;
    logic   flush;

    rv_fetch fetch_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .hold      (bubble),
        .redirect  (flush),
        .target    (ex_target),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_wdata(imem_wdata),
        .pc        (pc),
        .inst      (if_inst)
    );

    rv_decoder decoder_i (
        .inst(if_id_inst),
        .dec (id_dec)
    );

    rv_regfile regfile_i (
        .clk   (clk),
        .we    (me_wb.write_rd),
        .waddr (me_wb.rd),
        .raddr1(id_ex.dec.rs1),
        .raddr2(id_ex.dec.rs2),
        .wdata (me_wb.data),
        .rdata1(rf_rs1),
        .rdata2(rf_rs2)
    );

    rv_hazard hazard_i (
        .id_dec  (id_dec),
        .ex_stage(id_ex),
        .me_stage(ex_me),
        .wb_stage(me_wb),
        .me_data (me_data),
        .rf_rs1  (rf_rs1),
        .rf_rs2  (rf_rs2),
        .taken   (taken),
        .fwd_rs1 (fwd_rs1),
        .fwd_rs2 (fwd_rs2),
        .bubble  (bubble),
        .flush   (flush)
    );

    rv_execute execute_i (
        .stage  (id_ex),
        .rs1_val(fwd_rs1),
        .rs2_val(fwd_rs2),
        .result (ex_result),
        .taken  (taken),
        .target (ex_target)
    );

    rv_data_mem data_mem_i (
        .clk  (clk),
        .stage(ex_me),
        .rdata(dmem_rdata)
    );

    // Write-back value is known in the memory stage and forwarded from there.
    always_comb begin
        case (ex_me.wb_sel)
            WB_MEM:  me_data = dmem_rdata;
            WB_PC4:  me_data = ex_me.pc + xlen_t'(4);
            default: me_data = ex_me.alu_res;
        endcase
    end

    assign me_result.data     = me_data;
    assign me_result.rd       = ex_me.rd;
    assign me_result.write_rd = ex_me.write_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_inst <= '0;
            if_id_pc   <= '0;
            id_ex      <= '0;
            ex_me      <= '0;
            me_wb      <= '0;
        end else begin
            if (flush) begin
                if_id_inst <= '0;
                if_id_pc   <= '0;
            end else if (!bubble) begin
                if_id_inst <= if_inst;
                if_id_pc   <= pc;
            end
            if (flush || bubble) begin
                id_ex <= '0;
            end else begin
                id_ex <= '{dec: id_dec, pc: if_id_pc};
            end
            ex_me <= ex_result;
            me_wb <= me_result;
        end
    end

    assign commit_valid = me_wb.write_rd;
    assign commit_rd    = me_wb.rd;
    assign commit_data  = me_wb.data;

endmodule

//--- source/rv_data_mem.sv
module rv_data_mem (
    input  logic           clk,
    input  rv_pkg::ex_me_t stage,
    output rv_pkg::xlen_t  rdata
);
    import rv_pkg::*;

    xlen_t mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] index;

    // The low three address bits are the byte offset.
    assign index = stage.alu_res[DMEM_AW+2:3];

    always_ff @(posedge clk) begin
        if (stage.mem_write) begin
            mem[index] <= stage.store_data;
        end
    end

    assign rdata = mem[index];

    dmem_range_a: assert property (@(posedge clk)
        (stage.mem_read || stage.mem_write) |-> stage.alu_res < xlen_t'(DMEM_WORDS * 8));

endmodule

//--- source/rv_execute.sv
module rv_execute (
    input  rv_pkg::id_ex_t stage,
    input  rv_pkg::xlen_t  rs1_val,
    input  rv_pkg::xlen_t  rs2_val,
    output rv_pkg::ex_me_t result,
    output logic           taken,
    output rv_pkg::xlen_t  target
);
    import rv_pkg::*;

    xlen_t op_b;
    xlen_t alu_res;
    logic  equal;

    assign op_b  = stage.dec.use_imm ? stage.dec.imm : rs2_val;
    assign equal = (rs1_val == rs2_val);

    always_comb begin
        case (stage.dec.alu_op)
            ALU_ADD:    alu_res = rs1_val + op_b;
            ALU_SUB:    alu_res = rs1_val - op_b;
            ALU_AND:    alu_res = rs1_val & op_b;
            ALU_OR:     alu_res = rs1_val | op_b;
            ALU_XOR:    alu_res = rs1_val ^ op_b;
            ALU_SLT:    alu_res = xlen_t'($signed(rs1_val) < $signed(op_b));
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (stage.dec.br_kind)
            BR_BEQ:  taken = equal;
            BR_BNE:  taken = !equal;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Both branch and jal targets are pc relative.
    assign target = stage.pc + stage.dec.imm;

    assign result.alu_res    = alu_res;
    assign result.store_data = rs2_val;
    assign result.rd         = stage.dec.rd;
    assign result.write_rd   = stage.dec.write_rd;
    assign result.mem_read   = stage.dec.mem_read;
    assign result.mem_write  = stage.dec.mem_write;
    assign result.wb_sel     = stage.dec.wb_sel;
    assign result.pc         = stage.pc;

endmodule

//--- source/rv_hazard.sv
module rv_hazard (
    input  rv_pkg::dec_t   id_dec,
    input  rv_pkg::id_ex_t ex_stage,
    input  rv_pkg::ex_me_t me_stage,
    input  rv_pkg::me_wb_t wb_stage,
    input  rv_pkg::xlen_t  me_data,
    input  rv_pkg::xlen_t  rf_rs1,
    input  rv_pkg::xlen_t  rf_rs2,
    input  logic           taken,
    output rv_pkg::xlen_t  fwd_rs1,
    output rv_pkg::xlen_t  fwd_rs2,
    output logic           bubble,
    output logic           flush
);
    import rv_pkg::*;

    // Youngest producer wins.
    function automatic xlen_t pick(input reg_addr_t rs, input xlen_t rf_val);
        if (me_stage.write_rd && me_stage.rd == rs) begin
            return me_data;
        end else if (wb_stage.write_rd && wb_stage.rd == rs) begin
            return wb_stage.data;
        end
        return rf_val;
    endfunction

    always_comb begin
        fwd_rs1 = pick(ex_stage.dec.rs1, rf_rs1);
        fwd_rs2 = pick(ex_stage.dec.rs2, rf_rs2);
    end

    assign bubble = ex_stage.dec.mem_read && ex_stage.dec.write_rd &&
                    (id_dec.rs1 == ex_stage.dec.rd || id_dec.rs2 == ex_stage.dec.rd);

    assign flush = taken;

    // A load in execute is never the branch that resolves there.
    always_comb begin
        bubble_flush_a: assert (!(bubble && flush));
    end

endmodule

//--- source/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    input  rv_pkg::xlen_t     wdata,
    output rv_pkg::xlen_t     rdata1,
    output rv_pkg::xlen_t     rdata2
);
    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Entry 0 is never written, so x0 is forced on read.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // The decoder already clears write_rd for rd 0.
    no_x0_write_a: assert property (@(posedge clk) !(we && waddr == '0));

endmodule

//--- source/rv_decoder.sv
module rv_decoder (
    input  rv_pkg::inst_t inst,
    output rv_pkg::dec_t  dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Unused source fields stay zero, so they never match a destination.
    always_comb begin
        dec = '0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    dec.use_imm  = 1'b1;
                    dec.imm      = imm_i;
                    dec.rs1      = inst[19:15];
                    dec.rd       = inst[11:7];
                    dec.write_rd = 1'b1;
                end
            end
            OPC_OP: begin
                dec.rs1      = inst[19:15];
                dec.rs2      = inst[24:20];
                dec.rd       = inst[11:7];
                dec.write_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: dec.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: dec.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: dec.alu_op = ALU_SLT;
                    default:              dec = '0;
                endcase
            end
            OPC_LUI: begin
                dec.alu_op   = ALU_PASS_B;
                dec.use_imm  = 1'b1;
                dec.imm      = imm_u;
                dec.rd       = inst[11:7];
                dec.write_rd = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b011) begin
                    dec.use_imm  = 1'b1;
                    dec.imm      = imm_i;
                    dec.rs1      = inst[19:15];
                    dec.rd       = inst[11:7];
                    dec.write_rd = 1'b1;
                    dec.mem_read = 1'b1;
                    dec.wb_sel   = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    dec.use_imm   = 1'b1;
                    dec.imm       = imm_s;
                    dec.rs1       = inst[19:15];
                    dec.rs2       = inst[24:20];
                    dec.mem_write = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    dec.alu_op  = ALU_SUB;
                    dec.imm     = imm_b;
                    dec.rs1     = inst[19:15];
                    dec.rs2     = inst[24:20];
                    dec.br_kind = funct3[0] ? BR_BNE : BR_BEQ;
                end
            end
            OPC_JAL: begin
                dec.imm      = imm_j;
                dec.rd       = inst[11:7];
                dec.write_rd = 1'b1;
                dec.wb_sel   = WB_PC4;
                dec.br_kind  = BR_JAL;
            end
            default: dec = '0;
        endcase
        // Writes to x0 are dropped here and nowhere else.
        if (dec.rd == '0) begin
            dec.write_rd = 1'b0;
        end
    end

endmodule

//--- source/rv_fetch.sv
module rv_fetch (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       hold,
    input  logic                       redirect,
    input  rv_pkg::xlen_t              target,
    input  logic                       imem_we,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
    input  rv_pkg::inst_t              imem_wdata,
    output rv_pkg::xlen_t              pc,
    output rv_pkg::inst_t              inst
);
    import rv_pkg::*;

    inst_t imem [IMEM_WORDS];
    xlen_t pc_next;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign inst = imem[pc[IMEM_AW+1:2]];

    // A taken branch wins over the load-use hold.
    always_comb begin
        if (redirect) begin
            pc_next = target;
        end else if (hold) begin
            pc_next = pc;
        end else begin
            pc_next = pc + xlen_t'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    pc_aligned_a: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_WORDS = 32;
    localparam int DMEM_AW    = 5;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } br_kind_e;

    // An all-zero dec_t is a no-op.
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        xlen_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      write_rd;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   wb_sel;
        br_kind_e  br_kind;
    } dec_t;

    typedef struct packed {
        dec_t  dec;
        xlen_t pc;
    } id_ex_t;

    typedef struct packed {
        xlen_t     alu_res;
        xlen_t     store_data;
        reg_addr_t rd;
        logic      write_rd;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   wb_sel;
        xlen_t     pc;
    } ex_me_t;

    typedef struct packed {
        xlen_t     data;
        reg_addr_t rd;
        logic      write_rd;
    } me_wb_t;

endpackage
